/* hdl/fbuf_pkg.sv */
// Frame buffer shared definitions
package fbuf_pkg;

    // ----------------------------------------
    // Bus words and bursts.
    localparam int DATA_W      = 64;
    localparam int BEAT_BYTES  = DATA_W / 8;
    localparam int BURST_LEN   = 8;
    localparam int BURST_BYTES = BURST_LEN * BEAT_BYTES;

    typedef logic [DATA_W-1:0]            data_t;
    typedef logic [$clog2(BURST_LEN)-1:0] beat_cnt_t;
    typedef logic [31:0]                  addr_t;

    // ----------------------------------------
    // Frame slots of 1 KB each.
    localparam int OFFSET_W  = 10;
    localparam int NUM_SLOTS = 4;

    typedef logic [OFFSET_W-1:0]          offset_t;
    typedef logic [$clog2(NUM_SLOTS)-1:0] slot_t;

    localparam addr_t BASE_ADDR     = 32'h0001_0000;
    localparam int    READ_END      = 512;
    localparam slot_t WR_SLOT_RESET = slot_t'(0);
    localparam slot_t RD_SLOT_RESET = slot_t'(2);

    // ----------------------------------------
    // Pixel FIFOs and flush holds.
    localparam int FIFO_DEPTH      = 32;
    localparam int WR_FLUSH_CYCLES = 4;
    localparam int RD_FLUSH_CYCLES = 16;

    typedef logic [$clog2(FIFO_DEPTH)-1:0]      fifo_ptr_t;
    typedef logic [$clog2(FIFO_DEPTH):0]        fifo_cnt_t;
    typedef logic [$clog2(RD_FLUSH_CYCLES+1)-1:0] flush_cnt_t;

endpackage

/* hdl/sync_fifo.sv */
// Synchronous pixel FIFO
`timescale 1ns/1ps

module sync_fifo
    import fbuf_pkg::*;
#(
    parameter type payload_t = data_t
) (
    input  logic      axi_clk,
    input  logic      r_rfifo_rst,
    input  logic      flush_i,
    input  logic      wr_en_i,
    input  payload_t  wdata_i,
    input  logic      rd_en_i,
    output payload_t  rdata_o,
    output fifo_cnt_t count_o,
    output logic      empty_o
);

    payload_t  mem [FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    logic      full;
    logic      push;
    logic      pop;

    assign full    = (count_o == fifo_cnt_t'(FIFO_DEPTH));
    assign empty_o = (count_o == '0);
    assign push    = wr_en_i && !full;
    assign pop     = rd_en_i && !empty_o;

    always_ff @(posedge axi_clk) begin
        if (push) begin
            mem[wr_ptr] <= wdata_i;
        end
    end

    // Registered read that returns a stale word when empty.
    always_ff @(posedge axi_clk) begin
        if (rd_en_i) begin
            rdata_o <= mem[rd_ptr];
        end
    end

    always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
        if (r_rfifo_rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_o <= '0;
        end else if (flush_i) begin
            // Flush drops everything in one cycle.
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_o <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + fifo_ptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + fifo_ptr_t'(1);
            end
            count_o <= count_o + fifo_cnt_t'(push) - fifo_cnt_t'(pop);
        end
    end

endmodule

/* hdl/frame_writer.sv */
// Frame writer to AXI
`timescale 1ns/1ps

module frame_writer
    import fbuf_pkg::*;
(
    input  logic  axi_clk,
    input  logic  r_rfifo_rst,
    input  logic  wframe_vsync_i,
    input  logic  wframe_data_en_i,
    input  data_t wframe_data_i,
    input  slot_t wr_slot_i,
    output logic  wr_done_o,
    output addr_t awaddr_o,
    output logic  awvalid_o,
    input  logic  awready_i,
    output data_t wdata_o,
    output logic  wlast_o,
    output logic  wvalid_o,
    input  logic  wready_i
);

    typedef enum logic [1:0] {W_IDLE, W_DATA, W_INC, W_FLUSH} wr_state_t;

    wr_state_t  state;
    logic       vsync_q;
    logic       vsync_fall;
    logic       eof_pending;
    beat_cnt_t  beat_cnt;
    offset_t    offset;
    flush_cnt_t flush_cnt;
    fifo_cnt_t  fifo_count;
    logic       fifo_rd_en;
    logic       w_fire;
    logic       burst_go;
    logic       eof_go;

    assign vsync_fall = vsync_q && !wframe_vsync_i;
    assign w_fire     = wvalid_o && wready_i;
    assign wlast_o    = wvalid_o && (beat_cnt == beat_cnt_t'(BURST_LEN - 1));
    assign burst_go   = (state == W_IDLE) && (fifo_count >= fifo_cnt_t'(BURST_LEN));
    assign eof_go     = (state == W_IDLE) && !burst_go && eof_pending;
    assign awaddr_o   = BASE_ADDR + addr_t'({wr_slot_i, offset});

    // Prefetch the head word at burst start, then one per accepted beat.
    assign fifo_rd_en = burst_go || (w_fire && !wlast_o);

    sync_fifo #(
        .payload_t (data_t)
    ) u_wfifo (
        .axi_clk     (axi_clk),
        .r_rfifo_rst (r_rfifo_rst),
        .flush_i     (eof_go),
        .wr_en_i     (wframe_data_en_i),
        .wdata_i     (wframe_data_i),
        .rd_en_i     (fifo_rd_en),
        .rdata_o     (wdata_o),
        .count_o     (fifo_count),
        .empty_o     ()
    );

    // ----------------------------------------
    // Burst and end-of-frame control.
    always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
        if (r_rfifo_rst) begin
            state       <= W_IDLE;
            vsync_q     <= 1'b0;
            eof_pending <= 1'b0;
            beat_cnt    <= '0;
            offset      <= '0;
            flush_cnt   <= '0;
            awvalid_o   <= 1'b0;
            wvalid_o    <= 1'b0;
            wr_done_o   <= 1'b0;
        end else begin
            vsync_q   <= wframe_vsync_i;
            wr_done_o <= eof_go;
            if (vsync_fall) begin
                eof_pending <= 1'b1;
            end else if (eof_go) begin
                eof_pending <= 1'b0;
            end
            if (awvalid_o && awready_i) begin
                awvalid_o <= 1'b0;
            end
            case (state)
                W_IDLE: begin
                    if (burst_go) begin
                        awvalid_o <= 1'b1;
                        wvalid_o  <= 1'b1;
                        beat_cnt  <= '0;
                        state     <= W_DATA;
                    end else if (eof_go) begin
                        offset    <= '0;
                        flush_cnt <= '0;
                        state     <= W_FLUSH;
                    end
                end
                W_DATA: begin
                    if (w_fire) begin
                        beat_cnt <= beat_cnt + beat_cnt_t'(1);
                        if (wlast_o) begin
                            wvalid_o <= 1'b0;
                        end
                    end
                    // Leave only once both AW and the last W beat are taken.
                    if ((!wvalid_o || (w_fire && wlast_o)) && (!awvalid_o || awready_i)) begin
                        state <= W_INC;
                    end
                end
                W_INC: begin
                    offset <= offset + offset_t'(BURST_BYTES);
                    state  <= W_IDLE;
                end
                W_FLUSH: begin
                    if (flush_cnt == flush_cnt_t'(WR_FLUSH_CYCLES - 1)) begin
                        state <= W_IDLE;
                    end else begin
                        flush_cnt <= flush_cnt + flush_cnt_t'(1);
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

endmodule

/* hdl/frame_reader.sv */
// Frame reader from AXI
`timescale 1ns/1ps

module frame_reader
    import fbuf_pkg::*;
(
    input  logic  axi_clk,
    input  logic  r_rfifo_rst,
    input  logic  rframe_vsync_i,
    input  logic  rframe_data_en_i,
    output data_t rframe_data_o,
    output logic  rframe_empty_o,
    input  slot_t rd_slot_i,
    output logic  rd_start_o,
    output addr_t araddr_o,
    output logic  arvalid_o,
    input  logic  arready_i,
    input  data_t rdata_i,
    input  logic  rlast_i,
    input  logic  rvalid_i
);

    typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA} rd_state_t;

    rd_state_t  state;
    logic       vsync_q;
    logic       vsync_fall;
    flush_cnt_t settle_cnt;
    logic       rd_active;
    offset_t    offset;
    logic       beat_wr;
    data_t      beat_data;
    fifo_cnt_t  fifo_count;
    fifo_cnt_t  fill;
    logic       space_ok;
    logic       burst_go;

    assign vsync_fall = vsync_q && !rframe_vsync_i;
    assign araddr_o   = BASE_ADDR + addr_t'({rd_slot_i, offset});

    // A beat still in the input register counts as used space.
    assign fill     = fifo_count + fifo_cnt_t'(beat_wr);
    assign space_ok = (fill <= fifo_cnt_t'(FIFO_DEPTH - BURST_LEN));
    assign burst_go = (state == R_IDLE) && rd_active && space_ok
                      && (offset < offset_t'(READ_END));

    sync_fifo #(
        .payload_t (data_t)
    ) u_rfifo (
        .axi_clk     (axi_clk),
        .r_rfifo_rst (r_rfifo_rst),
        .flush_i     (vsync_fall),
        .wr_en_i     (beat_wr),
        .wdata_i     (beat_data),
        .rd_en_i     (rframe_data_en_i),
        .rdata_o     (rframe_data_o),
        .count_o     (fifo_count),
        .empty_o     (rframe_empty_o)
    );

    // ----------------------------------------
    // Flush, settle and frame start.
    always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
        if (r_rfifo_rst) begin
            vsync_q    <= 1'b0;
            settle_cnt <= '0;
            rd_active  <= 1'b0;
            rd_start_o <= 1'b0;
        end else begin
            vsync_q    <= rframe_vsync_i;
            rd_start_o <= 1'b0;
            if (vsync_fall) begin
                settle_cnt <= flush_cnt_t'(RD_FLUSH_CYCLES);
                rd_active  <= 1'b0;
            end else if (settle_cnt != '0) begin
                settle_cnt <= settle_cnt - flush_cnt_t'(1);
                if (settle_cnt == flush_cnt_t'(1)) begin
                    rd_start_o <= 1'b1;
                    rd_active  <= 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // Read bursts with one outstanding.
    always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
        if (r_rfifo_rst) begin
            state     <= R_IDLE;
            arvalid_o <= 1'b0;
            offset    <= '0;
        end else begin
            if (vsync_fall) begin
                offset <= '0;
            end else if (arvalid_o && arready_i) begin
                offset <= offset + offset_t'(BURST_BYTES);
            end
            case (state)
                R_IDLE: begin
                    if (burst_go) begin
                        arvalid_o <= 1'b1;
                        state     <= R_ADDR;
                    end
                end
                R_ADDR: begin
                    if (arready_i) begin
                        arvalid_o <= 1'b0;
                        state     <= R_DATA;
                    end
                end
                R_DATA: begin
                    if (rvalid_i && rlast_i) begin
                        state <= R_IDLE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // Every read beat goes into the FIFO one cycle later.
    always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
        if (r_rfifo_rst) begin
            beat_wr <= 1'b0;
        end else begin
            beat_wr <= rvalid_i;
        end
    end

    always_ff @(posedge axi_clk) begin
        beat_data <= rdata_i;
    end

endmodule

/* hdl/frame_scheduler.sv */
// Frame slot scheduler
`timescale 1ns/1ps

module frame_scheduler
    import fbuf_pkg::*;
(
    input  logic  axi_clk,
    input  logic  r_rfifo_rst,
    input  logic  wr_done_i,
    input  logic  rd_start_i,
    output slot_t wr_slot_o,
    output slot_t rd_slot_o
);

    slot_t last_slot;
    slot_t wr_p1;
    slot_t wr_next;

    // Step the write slot past the one being read.
    assign wr_p1   = wr_slot_o + slot_t'(1);
    assign wr_next = (wr_p1 == rd_slot_o) ? wr_slot_o + slot_t'(2) : wr_p1;

    always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
        if (r_rfifo_rst) begin
            wr_slot_o <= WR_SLOT_RESET;
            rd_slot_o <= RD_SLOT_RESET;
            last_slot <= WR_SLOT_RESET;
        end else begin
            case ({rd_start_i, wr_done_i})
                2'b01: begin
                    wr_slot_o <= wr_next;
                    last_slot <= wr_slot_o;
                end
                2'b10: begin
                    rd_slot_o <= last_slot;
                end
                2'b11: begin
                    // Reader takes the frame that just finished.
                    wr_slot_o <= wr_next;
                    rd_slot_o <= wr_slot_o;
                end
                default: ;
            endcase
        end
    end

endmodule

/* hdl/frame_buffer_top.sv */
// Video frame buffer controller
`timescale 1ns/1ps

module frame_buffer_top
    import fbuf_pkg::*;
(
    input  logic  axi_clk,
    input  logic  r_rfifo_rst,
    // Pixel input.
    input  logic  wframe_vsync_i,
    input  logic  wframe_data_en_i,
    input  data_t wframe_data_i,
    // Pixel output.
    input  logic  rframe_vsync_i,
    input  logic  rframe_data_en_i,
    output data_t rframe_data_o,
    output logic  rframe_empty_o,
    // AXI write.
    output addr_t awaddr_o,
    output logic  awvalid_o,
    input  logic  awready_i,
    output data_t wdata_o,
    output logic  wlast_o,
    output logic  wvalid_o,
    input  logic  wready_i,
    // AXI read.
    output addr_t araddr_o,
    output logic  arvalid_o,
    input  logic  arready_i,
    input  data_t rdata_i,
    input  logic  rlast_i,
    input  logic  rvalid_i
);

    logic  wr_done;
    logic  rd_start;
    slot_t wr_slot;
    slot_t rd_slot;

    frame_writer u_writer (
        .axi_clk          (axi_clk),
        .r_rfifo_rst      (r_rfifo_rst),
        .wframe_vsync_i   (wframe_vsync_i),
        .wframe_data_en_i (wframe_data_en_i),
        .wframe_data_i    (wframe_data_i),
        .wr_slot_i        (wr_slot),
        .wr_done_o        (wr_done),
        .awaddr_o         (awaddr_o),
        .awvalid_o        (awvalid_o),
        .awready_i        (awready_i),
        .wdata_o          (wdata_o),
        .wlast_o          (wlast_o),
        .wvalid_o         (wvalid_o),
        .wready_i         (wready_i)
    );

    frame_reader u_reader (
        .axi_clk          (axi_clk),
        .r_rfifo_rst      (r_rfifo_rst),
        .rframe_vsync_i   (rframe_vsync_i),
        .rframe_data_en_i (rframe_data_en_i),
        .rframe_data_o    (rframe_data_o),
        .rframe_empty_o   (rframe_empty_o),
        .rd_slot_i        (rd_slot),
        .rd_start_o       (rd_start),
        .araddr_o         (araddr_o),
        .arvalid_o        (arvalid_o),
        .arready_i        (arready_i),
        .rdata_i          (rdata_i),
        .rlast_i          (rlast_i),
        .rvalid_i         (rvalid_i)
    );

    frame_scheduler u_sched (
        .axi_clk     (axi_clk),
        .r_rfifo_rst (r_rfifo_rst),
        .wr_done_i   (wr_done),
        .rd_start_i  (rd_start),
        .wr_slot_o   (wr_slot),
        .rd_slot_o   (rd_slot)
    );

endmodule

/* testbench/tb_frame_buffer.sv */
// Frame buffer testbench
`timescale 1ns/1ps

module tb_frame_buffer
    import fbuf_pkg::*;
;

    localparam int NUM_FRAMES  = 6;
    localparam int MIN_BURSTS  = 8;
    localparam int MAX_BURSTS  = 12;
    localparam int SLOT_WORDS  = (1 << OFFSET_W) / BEAT_BYTES;
    localparam int READ_WORDS  = READ_END / BEAT_BYTES;
    localparam int FRAME_CYC   = MAX_BURSTS * BURST_LEN * 4 + READ_WORDS * 4;
    localparam int CYCLE_LIMIT = 2 * NUM_FRAMES * FRAME_CYC
                                 + NUM_FRAMES * (WR_FLUSH_CYCLES + RD_FLUSH_CYCLES + 16);

    logic  axi_clk;
    logic  r_rfifo_rst;
    logic  wframe_vsync_i;
    logic  wframe_data_en_i;
    data_t wframe_data_i;
    logic  rframe_vsync_i;
    logic  rframe_data_en_i;
    data_t rframe_data_o;
    logic  rframe_empty_o;
    addr_t awaddr_o;
    logic  awvalid_o;
    logic  awready_i;
    data_t wdata_o;
    logic  wlast_o;
    logic  wvalid_o;
    logic  wready_i;
    addr_t araddr_o;
    logic  arvalid_o;
    logic  arready_i;
    data_t rdata_i;
    logic  rlast_i;
    logic  rvalid_i;

    // Memory model and slot model.
    data_t mem [NUM_SLOTS * SLOT_WORDS];
    data_t push_q [$];
    slot_t m_ws;
    slot_t m_rs;
    slot_t m_last;
    int    cycle_cnt;
    int    aw_bursts;
    int    frame_beat;
    int    rd_off;
    int    r_idx;
    int    r_left;
    int    r_delay;
    int    popped;
    bit    pop_pending;
    bit    drain_on;

    frame_buffer_top u_dut (.*);

    initial begin
        axi_clk = 1'b0;
        forever #2 axi_clk = ~axi_clk;
    end

    // ----------------------------------------
    // Checks.
    task automatic fail_stop();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped at first error.");
    endtask

    task automatic report_error(input string msg);
        $display("Error: %s", msg);
        fail_stop();
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_slot(input string name, input slot_t got, input slot_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            fail_stop();
        end
    endtask

    // Each slot spans 1 KB above the base address.
    function automatic addr_t slot_addr(input slot_t s, input int off);
        return BASE_ADDR + (addr_t'(s) << OFFSET_W) + addr_t'(off);
    endfunction

    // Write slot steps by one, or by two to stay off the read slot.
    function automatic slot_t advance_slot(input slot_t ws, input slot_t rs);
        slot_t p1;
        p1 = ws + slot_t'(1);
        return (p1 == rs) ? ws + slot_t'(2) : p1;
    endfunction

    // ----------------------------------------
    // Sample handshakes at the falling edge and drive after the rising edge.
    task automatic step();
        data_t exp_w;
        @(negedge axi_clk);
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            report_error($sformatf("timeout after %0d cycles", CYCLE_LIMIT));
        end
        if (pop_pending) begin
            check_data("rframe_data_o", rframe_data_o, mem[m_rs * SLOT_WORDS + popped]);
            popped++;
            pop_pending = 1'b0;
        end
        if (rframe_data_en_i && !rframe_empty_o) begin
            pop_pending = 1'b1;
        end
        if (awvalid_o && awready_i) begin
            if (aw_bursts == 0) begin
                check_slot("awaddr_o slot", slot_t'((awaddr_o - BASE_ADDR) >> OFFSET_W), m_ws);
            end
            check_addr("awaddr_o", awaddr_o, slot_addr(m_ws, aw_bursts * BURST_BYTES));
            aw_bursts++;
        end
        if (wvalid_o && wready_i) begin
            if (push_q.size() == 0) begin
                report_error("write beat accepted with no pixel word pending");
            end
            exp_w = push_q.pop_front();
            check_data("wdata_o", wdata_o, exp_w);
            check_flag("wlast_o", wlast_o, (frame_beat % BURST_LEN) == BURST_LEN - 1);
            mem[m_ws * SLOT_WORDS + frame_beat] = exp_w;
            frame_beat++;
        end
        if (rvalid_i) begin
            r_idx++;
            r_left--;
        end
        if (arvalid_o && arready_i) begin
            if (rd_off >= READ_END) begin
                report_error("read burst issued past the end of the frame");
            end
            if (r_left != 0) begin
                report_error("second read burst issued while one is outstanding");
            end
            check_addr("araddr_o", araddr_o, slot_addr(m_rs, rd_off));
            r_idx   = m_rs * SLOT_WORDS + rd_off / BEAT_BYTES;
            r_left  = BURST_LEN;
            r_delay = $urandom % 6;
            rd_off += BURST_BYTES;
        end
        @(posedge axi_clk);
        #1;
        awready_i = ($urandom % 4) != 0;
        wready_i  = ($urandom % 4) != 0;
        arready_i = ($urandom % 3) != 0;
        if (r_left > 0 && r_delay > 0) begin
            r_delay--;
            rvalid_i = 1'b0;
            rlast_i  = 1'b0;
        end else if (r_left > 0 && ($urandom % 4) != 0) begin
            rvalid_i = 1'b1;
            rdata_i  = mem[r_idx];
            rlast_i  = (r_left == 1);
        end else begin
            rvalid_i = 1'b0;
            rlast_i  = 1'b0;
        end
        rframe_data_en_i = drain_on && !rframe_empty_o
                           && (popped + int'(pop_pending) < READ_WORDS);
    endtask

    // ----------------------------------------
    // Frame sequences.
    task automatic write_frame();
        int n;
        int pushed;
        n          = BURST_LEN * (MIN_BURSTS + $urandom % (MAX_BURSTS - MIN_BURSTS + 1));
        pushed     = 0;
        aw_bursts  = 0;
        frame_beat = 0;
        while (pushed < n) begin
            if (pushed - frame_beat < 24 && ($urandom % 4) != 0) begin
                wframe_data_en_i = 1'b1;
                wframe_data_i    = {$urandom, $urandom};
                push_q.push_back(wframe_data_i);
                pushed++;
            end else begin
                wframe_data_en_i = 1'b0;
            end
            step();
        end
        wframe_data_en_i = 1'b0;
        while (frame_beat < n) begin
            step();
        end
        repeat (4) step();
        if (aw_bursts != n / BURST_LEN) begin
            report_error($sformatf("saw %0d write addresses for %0d bursts",
                                   aw_bursts, n / BURST_LEN));
        end
    endtask

    task automatic end_write();
        wframe_vsync_i = 1'b0;
        m_last = m_ws;
        m_ws   = advance_slot(m_ws, m_rs);
        repeat (2) step();
        wframe_vsync_i = 1'b1;
        repeat (WR_FLUSH_CYCLES + 4) step();
    endtask

    task automatic start_read();
        rframe_vsync_i = 1'b0;
        m_rs   = m_last;
        rd_off = 0;
        step();
        rframe_vsync_i = 1'b1;
    endtask

    // Read fall leads the write fall so that rd_start and wr_done meet.
    task automatic coincide_end();
        slot_t ws_done;
        rframe_vsync_i = 1'b0;
        rd_off = 0;
        step();
        rframe_vsync_i = 1'b1;
        repeat (RD_FLUSH_CYCLES - 2) step();
        wframe_vsync_i = 1'b0;
        ws_done = m_ws;
        m_ws    = advance_slot(m_ws, m_rs);
        m_rs    = ws_done;
        repeat (2) step();
        wframe_vsync_i = 1'b1;
        repeat (WR_FLUSH_CYCLES + 4) step();
    endtask

    task automatic drain_frame();
        popped   = 0;
        drain_on = 1'b1;
        while (popped < READ_WORDS) begin
            step();
        end
        drain_on = 1'b0;
        repeat (4) step();
        if (rd_off != READ_END) begin
            report_error($sformatf("reader fetched %0d bytes per frame", rd_off));
        end
        // Whole frame popped, so the output FIFO holds nothing.
        check_flag("rframe_empty_o", rframe_empty_o, 1'b1);
    endtask

    initial begin
        r_rfifo_rst      = 1'b1;
        wframe_vsync_i   = 1'b1;
        wframe_data_en_i = 1'b0;
        wframe_data_i    = '0;
        rframe_vsync_i   = 1'b1;
        rframe_data_en_i = 1'b0;
        awready_i        = 1'b0;
        wready_i         = 1'b0;
        arready_i        = 1'b0;
        rdata_i          = '0;
        rlast_i          = 1'b0;
        rvalid_i         = 1'b0;
        void'($urandom(33));
        for (int i = 0; i < NUM_SLOTS * SLOT_WORDS; i++) begin
            mem[i] = {32'hc0de_0000 ^ 32'(i), ~32'(i * 7)};
        end
        m_ws        = WR_SLOT_RESET;
        m_rs        = RD_SLOT_RESET;
        m_last      = WR_SLOT_RESET;
        cycle_cnt   = 0;
        rd_off      = 0;
        r_left      = 0;
        r_delay     = 0;
        r_idx       = 0;
        popped      = 0;
        pop_pending = 1'b0;
        drain_on    = 1'b0;
        repeat (8) @(posedge axi_clk);
        #1;
        r_rfifo_rst = 1'b0;
        step();
        // First frame is written without a read, so the second one skips the read slot.
        for (int f = 0; f < NUM_FRAMES; f++) begin
            write_frame();
            if (f == 0) begin
                end_write();
            end else if (f == 3 || f == 5) begin
                coincide_end();
                drain_frame();
            end else begin
                end_write();
                start_read();
                drain_frame();
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* project.f */
hdl/fbuf_pkg.sv
hdl/sync_fifo.sv
hdl/frame_writer.sv
hdl/frame_reader.sv
hdl/frame_scheduler.sv
hdl/frame_buffer_top.sv
testbench/tb_frame_buffer.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the frame buffer simulation with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_frame_buffer -f project.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation passed."
    exit 0
else
    echo "Simulation failed."
    exit 1
fi
